// ==== src/zynq_shell_pkg.sv ====
package zynq_shell_pkg;

   ////////////////////////////////////////////////////////////
   // host register interface
   ////////////////////////////////////////////////////////////

   localparam int host_data_width = 32;
   localparam int host_addr_width = 4;

   // word index of each host register
   typedef enum logic [host_addr_width-1:0] {
      reg_sys_reset_n  = 4'd0,
      reg_dram_init    = 4'd1,
      reg_dram_base    = 4'd2,
      reg_bootrom_addr = 4'd3,
      reg_irq          = 4'd4,
      reg_freeze       = 4'd5,
      // read-only status
      reg_credits      = 4'd8,
      reg_minstret_lo  = 4'd9,
      reg_minstret_hi  = 4'd10,
      reg_bootrom_data = 4'd11
   } host_reg_e;

   // interrupt lines towards the core
   typedef struct packed {
      logic debug;
      logic timer;
      logic software;
      logic m_external;
      logic s_external;
   } irq_vec_t;

   // decoded control registers
   typedef struct packed {
      logic                       sys_reset_n;
      logic                       dram_init;
      logic [host_data_width-1:0] dram_base;
      logic [host_addr_width-1:0] bootrom_addr;
      irq_vec_t                   irq;
      logic                       freeze;
   } shell_ctrl_t;

   ////////////////////////////////////////////////////////////
   // memory path
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                       valid;
      logic                       write;
      logic [host_data_width-1:0] addr;
   } mem_req_t;

   // start of DRAM as the processor sees it
   localparam logic [host_data_width-1:0] bp_dram_base = 32'h8000_0000;
   // 256 MiB host window
   localparam logic [host_data_width-1:0] dram_window_limit = 32'h1000_0000;

endpackage

// ==== src/host_csr_bank.sv ====
`timescale 1ns/1ps

module host_csr_bank
  (input  logic                                          aclk_i
   , input  logic                                        rst_n_i
   , input  logic                                        host_we_i
   , input  zynq_shell_pkg::host_reg_e                   host_addr_i
   , input  logic [zynq_shell_pkg::host_data_width-1:0]  host_wdata_i
   , input  logic                                        credits_busy_i
   , input  logic [2*zynq_shell_pkg::host_data_width-1:0] minstret_i
   , input  logic [zynq_shell_pkg::host_data_width-1:0]  rom_data_i
   , output zynq_shell_pkg::shell_ctrl_t                 ctrl_o
   , output logic [zynq_shell_pkg::host_data_width-1:0]  host_rdata_o
   );

   localparam int num_wr_regs = 6;

   logic [num_wr_regs-1:0][zynq_shell_pkg::host_data_width-1:0] wr_regs_q;
   logic                                                         wr_hit;

   // only indexes 0 to 5 hold storage
   always_comb
   begin
      case (host_addr_i)
         zynq_shell_pkg::reg_sys_reset_n,
         zynq_shell_pkg::reg_dram_init,
         zynq_shell_pkg::reg_dram_base,
         zynq_shell_pkg::reg_bootrom_addr,
         zynq_shell_pkg::reg_irq,
         zynq_shell_pkg::reg_freeze:
            wr_hit = 1'b1;
         default:
            wr_hit = 1'b0;
      endcase
   end

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_regs_q <= '0;
      end
      else if (host_we_i && wr_hit)
      begin
         wr_regs_q[host_addr_i] <= host_wdata_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // decode into control fields
   ////////////////////////////////////////////////////////////

   assign ctrl_o.sys_reset_n  = wr_regs_q[zynq_shell_pkg::reg_sys_reset_n][0];
   assign ctrl_o.dram_init    = wr_regs_q[zynq_shell_pkg::reg_dram_init][0];
   assign ctrl_o.dram_base    = wr_regs_q[zynq_shell_pkg::reg_dram_base];
   assign ctrl_o.bootrom_addr =
      wr_regs_q[zynq_shell_pkg::reg_bootrom_addr][zynq_shell_pkg::host_addr_width-1:0];
   assign ctrl_o.freeze       = wr_regs_q[zynq_shell_pkg::reg_freeze][0];

   // irq bits 0 to 4 in the order of the core's interrupt ports
   assign ctrl_o.irq.debug      = wr_regs_q[zynq_shell_pkg::reg_irq][0];
   assign ctrl_o.irq.timer      = wr_regs_q[zynq_shell_pkg::reg_irq][1];
   assign ctrl_o.irq.software   = wr_regs_q[zynq_shell_pkg::reg_irq][2];
   assign ctrl_o.irq.m_external = wr_regs_q[zynq_shell_pkg::reg_irq][3];
   assign ctrl_o.irq.s_external = wr_regs_q[zynq_shell_pkg::reg_irq][4];

   ////////////////////////////////////////////////////////////
   // host read-back
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      host_rdata_o = '0;
      if (wr_hit)
      begin
         host_rdata_o = wr_regs_q[host_addr_i];
      end
      else
      begin
         case (host_addr_i)
            zynq_shell_pkg::reg_credits:
               host_rdata_o[0] = credits_busy_i;
            zynq_shell_pkg::reg_minstret_lo:
               host_rdata_o = minstret_i[zynq_shell_pkg::host_data_width-1:0];
            zynq_shell_pkg::reg_minstret_hi:
               host_rdata_o = minstret_i[2*zynq_shell_pkg::host_data_width-1:
                                         zynq_shell_pkg::host_data_width];
            zynq_shell_pkg::reg_bootrom_data:
               host_rdata_o = rom_data_i;
            default:
               host_rdata_o = '0;
         endcase
      end
   end

endmodule

// ==== src/boot_rom.sv ====
`timescale 1ns/1ps

module boot_rom
  #(parameter int rom_depth = 16)
  (input  logic [zynq_shell_pkg::host_addr_width-1:0]   addr_i
   , output logic [zynq_shell_pkg::host_data_width-1:0] data_o
   );

   localparam string rom_file = "src/boot_rom.mem";

   logic [zynq_shell_pkg::host_data_width-1:0] rom_mem [rom_depth];

   // contents fixed at elaboration
   initial
   begin
      $readmemh(rom_file, rom_mem);
   end

   // addresses past the end read zero
   assign data_o = (addr_i < rom_depth) ? rom_mem[addr_i] : '0;

endmodule

// ==== src/dram_addr_xlate.sv ====
`timescale 1ns/1ps

module dram_addr_xlate
  (input  logic                          aclk_i
   , input  logic                        rst_n_i
   , input  zynq_shell_pkg::shell_ctrl_t ctrl_i
   , input  zynq_shell_pkg::mem_req_t    mem_req_i
   , output zynq_shell_pkg::mem_req_t    axi_req_o
   , output logic                        xlate_err_o
   );

   logic [zynq_shell_pkg::host_data_width-1:0] offset;
   logic [zynq_shell_pkg::host_data_width-1:0] addr_q;
   logic                                       accept;
   logic                                       valid_q;
   logic                                       err_q;
   logic                                       write_q;

   // xor strips the processor DRAM base and leaves the window offset
   assign offset = mem_req_i.addr ^ zynq_shell_pkg::bp_dram_base;
   assign accept = ctrl_i.dram_init && (offset < zynq_shell_pkg::dram_window_limit);

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         valid_q <= 1'b0;
         err_q   <= 1'b0;
      end
      else if (!ctrl_i.sys_reset_n)
      begin
         // core held in soft reset
         valid_q <= 1'b0;
         err_q   <= 1'b0;
      end
      else
      begin
         valid_q <= mem_req_i.valid && accept;
         err_q   <= mem_req_i.valid && !accept;
      end
   end

   // payload of the outgoing request
   always_ff @(posedge aclk_i)
   begin
      if (mem_req_i.valid)
      begin
         write_q <= mem_req_i.write;
         addr_q  <= offset + ctrl_i.dram_base;
      end
   end

   assign axi_req_o.valid = valid_q;
   assign axi_req_o.write = write_q;
   assign axi_req_o.addr  = addr_q;
   assign xlate_err_o     = err_q;

endmodule

// ==== src/io_credit_counter.sv ====
`timescale 1ns/1ps

module io_credit_counter
  #(parameter int num_credits = 32)
  (input  logic   aclk_i
   , input  logic rst_n_i
   , input  logic soft_rst_n_i
   , input  logic io_req_i
   , input  logic io_resp_i
   , output logic busy_o
   , output logic stall_o
   );

   localparam int cnt_width = $clog2(num_credits + 1);
   localparam logic [cnt_width-1:0] full_cnt = cnt_width'(num_credits);

   logic [cnt_width-1:0] cnt_q;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         cnt_q <= '0;
      end
      else if (!soft_rst_n_i)
      begin
         cnt_q <= '0;
      end
      else if (io_req_i && !io_resp_i && (cnt_q != full_cnt))
      begin
         cnt_q <= cnt_q + 1'b1;
      end
      else if (io_resp_i && !io_req_i && (cnt_q != '0))
      begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   assign busy_o  = |cnt_q;
   assign stall_o = (cnt_q == full_cnt);

endmodule

// ==== src/retire_counter.sv ====
`timescale 1ns/1ps

module retire_counter
  (input  logic                                            aclk_i
   , input  logic                                          rst_n_i
   , input  logic                                          soft_rst_n_i
   , input  logic                                          freeze_i
   , input  logic                                          retire_i
   , output logic [2*zynq_shell_pkg::host_data_width-1:0]  count_o
   );

   logic [2*zynq_shell_pkg::host_data_width-1:0] count_q;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         count_q <= '0;
      end
      else if (!soft_rst_n_i)
      begin
         count_q <= '0;
      end
      else if (retire_i && !freeze_i)
      begin
         count_q <= count_q + 1'b1;
      end
   end

   assign count_o = count_q;

endmodule

// ==== src/zynq_shell.sv ====
`timescale 1ns/1ps

module zynq_shell
  #(parameter int num_credits = 32
    , parameter int rom_depth = 16
    )
  (input  logic                                          aclk_i
   , input  logic                                        rst_n_i

   // host register port
   , input  logic                                        host_we_i
   , input  zynq_shell_pkg::host_reg_e                   host_addr_i
   , input  logic [zynq_shell_pkg::host_data_width-1:0]  host_wdata_i
   , output logic [zynq_shell_pkg::host_data_width-1:0]  host_rdata_o

   // core events
   , input  logic                                        retire_i
   , input  logic                                        io_req_i
   , input  logic                                        io_resp_i
   , output logic                                        io_stall_o

   // memory path
   , input  zynq_shell_pkg::mem_req_t                    mem_req_i
   , output zynq_shell_pkg::mem_req_t                    axi_req_o
   , output logic                                        xlate_err_o

   , output logic                                        core_reset_n_o
   , output zynq_shell_pkg::irq_vec_t                    irq_o
   );

   zynq_shell_pkg::shell_ctrl_t                  ctrl;
   logic                                         credits_busy;
   logic [2*zynq_shell_pkg::host_data_width-1:0] minstret;
   logic [zynq_shell_pkg::host_data_width-1:0]   rom_data;

   host_csr_bank i_csr_bank
     (.aclk_i          (aclk_i)
      ,.rst_n_i        (rst_n_i)
      ,.host_we_i      (host_we_i)
      ,.host_addr_i    (host_addr_i)
      ,.host_wdata_i   (host_wdata_i)
      ,.credits_busy_i (credits_busy)
      ,.minstret_i     (minstret)
      ,.rom_data_i     (rom_data)
      ,.ctrl_o         (ctrl)
      ,.host_rdata_o   (host_rdata_o)
      );

   boot_rom #(.rom_depth(rom_depth)) i_boot_rom
     (.addr_i  (ctrl.bootrom_addr)
      ,.data_o (rom_data)
      );

   dram_addr_xlate i_dram_xlate
     (.aclk_i       (aclk_i)
      ,.rst_n_i     (rst_n_i)
      ,.ctrl_i      (ctrl)
      ,.mem_req_i   (mem_req_i)
      ,.axi_req_o   (axi_req_o)
      ,.xlate_err_o (xlate_err_o)
      );

   io_credit_counter #(.num_credits(num_credits)) i_io_credits
     (.aclk_i        (aclk_i)
      ,.rst_n_i      (rst_n_i)
      ,.soft_rst_n_i (ctrl.sys_reset_n)
      ,.io_req_i     (io_req_i)
      ,.io_resp_i    (io_resp_i)
      ,.busy_o       (credits_busy)
      ,.stall_o      (io_stall_o)
      );

   retire_counter i_retire_cnt
     (.aclk_i        (aclk_i)
      ,.rst_n_i      (rst_n_i)
      ,.soft_rst_n_i (ctrl.sys_reset_n)
      ,.freeze_i     (ctrl.freeze)
      ,.retire_i     (retire_i)
      ,.count_o      (minstret)
      );

   // the core stays in soft reset until the host releases it
   assign core_reset_n_o = ctrl.sys_reset_n;
   assign irq_o          = ctrl.irq;

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
  #(parameter int period_ns = 20
    , parameter int reset_cycles = 10
    )
  (output logic clk_o
   , output logic rst_n_o
   );

   initial
   begin
      clk_o = 1'b0;
      forever #(period_ns / 2) clk_o = ~clk_o;
   end

   // release on a falling edge away from the active edge
   initial
   begin
      rst_n_o = 1'b0;
      repeat (reset_cycles) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

// ==== verification/tb_zynq_shell.sv ====
`timescale 1ns/1ps

module tb_zynq_shell;

   localparam int num_credits = 32;
   localparam int rom_depth   = 16;
   localparam int wait_limit  = 8;
   localparam int settle      = 5;
   localparam logic [31:0] window_base = 32'h8000_0000;
   localparam logic [31:0] window_size = 32'h1000_0000;

   typedef enum {op_write, op_read, op_mem, op_retire, op_io, op_pin} op_e;

   typedef struct {
      int          test;
      op_e         op;
      logic [3:0]  addr;
      logic [31:0] data;
      logic [31:0] exp;
      string       sig;
   } row_t;

   logic                      clk;
   logic                      rst_n;
   logic                      host_we;
   zynq_shell_pkg::host_reg_e host_addr;
   logic [31:0]               host_wdata;
   logic [31:0]               host_rdata;
   logic                      retire;
   logic                      io_req;
   logic                      io_resp;
   logic                      io_stall;
   zynq_shell_pkg::mem_req_t  mem_req;
   zynq_shell_pkg::mem_req_t  axi_req;
   logic                      xlate_err;
   logic                      core_reset_n;
   zynq_shell_pkg::irq_vec_t  irq;

   row_t        rows[$];
   logic [31:0] rom_words [rom_depth];
   int          cur_test;
   int          errors;
   int          checks;
   string       test_names [1:5] = '{"reset and register access", "boot rom",
                                     "dram translation", "retire count", "io credits"};

   tb_clock_gen #(.period_ns(20), .reset_cycles(10)) i_clock_gen
     (.clk_o    (clk)
      ,.rst_n_o (rst_n)
      );

   zynq_shell #(.num_credits(num_credits), .rom_depth(rom_depth)) i_zynq_shell
     (.aclk_i          (clk)
      ,.rst_n_i        (rst_n)
      ,.host_we_i      (host_we)
      ,.host_addr_i    (host_addr)
      ,.host_wdata_i   (host_wdata)
      ,.host_rdata_o   (host_rdata)
      ,.retire_i       (retire)
      ,.io_req_i       (io_req)
      ,.io_resp_i      (io_resp)
      ,.io_stall_o     (io_stall)
      ,.mem_req_i      (mem_req)
      ,.axi_req_o      (axi_req)
      ,.xlate_err_o    (xlate_err)
      ,.core_reset_n_o (core_reset_n)
      ,.irq_o          (irq)
      );

   ////////////////////////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////////////////////////

   task automatic add_row(input op_e op, input logic [3:0] addr, input logic [31:0] data,
                          input logic [31:0] exp, input string sig);
      rows.push_back('{cur_test, op, addr, data, exp, sig});
   endtask

   // accept when dram_init is set and the offset lies inside the window
   task automatic add_mem_row(input logic [31:0] addr, input logic write, input logic init,
                              input logic [31:0] base);
      logic [31:0] offset;
      offset = addr ^ window_base;
      if (init && (offset < window_size))
         add_row(op_mem, {3'b0, write}, addr, offset + base, "axi_req_o.addr");
      else
         add_row(op_mem, {3'b0, write}, addr, 32'h0, "xlate_err_o");
   endtask

   task automatic build_table();
      logic [31:0] v;
      logic [31:0] base;
      logic [31:0] a;
      int          k;

      cur_test = 1;
      for (int i = 0; i < 6; i++)
         add_row(op_read, 4'(i), 0, 0, "host_rdata_o");
      add_row(op_pin, 0, 0, 0, "core_reset_n_o");
      add_row(op_pin, 0, 0, 0, "irq_o");
      add_row(op_pin, 0, 0, 0, "io_stall_o");
      add_row(op_pin, 0, 0, 0, "xlate_err_o");
      add_row(op_pin, 0, 0, 0, "axi_req_o.valid");
      for (int i = 1; i < 6; i++)
      begin
         v = $urandom;
         add_row(op_write, 4'(i), v, 0, "");
         add_row(op_read, 4'(i), 0, v, "host_rdata_o");
         // debug comes from bit 0 and s_external from bit 4
         if (i == 4)
            add_row(op_pin, 0, 0, {27'b0, v[0], v[1], v[2], v[3], v[4]}, "irq_o");
      end
      add_row(op_write, 4'd0, 1, 0, "");
      add_row(op_read, 4'd0, 0, 1, "host_rdata_o");
      add_row(op_pin, 0, 0, 1, "core_reset_n_o");
      add_row(op_write, 4'd5, 0, 0, "");
      add_row(op_write, 4'd7, 32'h1234_5678, 0, "");
      add_row(op_read, 4'd7, 0, 0, "host_rdata_o");
      add_row(op_read, 4'd12, 0, 0, "host_rdata_o");

      cur_test = 2;
      for (int n = 0; n < rom_depth; n++)
      begin
         add_row(op_write, 4'd3, n, 0, "");
         add_row(op_read, 4'd11, 0, rom_words[n], "host_rdata_o");
      end

      cur_test = 3;
      base = $urandom;
      add_row(op_write, 4'd1, 0, 0, "");
      add_mem_row(32'h8000_0100, 1'b0, 1'b0, base);
      add_mem_row(32'h8123_4560, 1'b1, 1'b0, base);
      add_row(op_write, 4'd2, base, 0, "");
      add_row(op_write, 4'd1, 1, 0, "");
      // both ends of the window and just past it
      add_mem_row(32'h8000_0000, 1'b0, 1'b1, base);
      add_mem_row(32'h8fff_fffc, 1'b1, 1'b1, base);
      add_mem_row(32'h9000_0000, 1'b0, 1'b1, base);
      add_mem_row(32'h0000_0000, 1'b1, 1'b1, base);
      for (int i = 0; i < 8; i++)
      begin
         a = $urandom;
         if (i % 2 == 0)
            a = {4'h8, a[27:0]};
         add_mem_row(a, a[2], 1'b1, base);
      end

      cur_test = 4;
      k = 1 + ($urandom % 20);
      add_row(op_retire, 0, k, 0, "");
      add_row(op_read, 4'd9, 0, k, "host_rdata_o");
      add_row(op_read, 4'd10, 0, 0, "host_rdata_o");
      add_row(op_write, 4'd5, 1, 0, "");
      add_row(op_retire, 0, 5, 0, "");
      add_row(op_read, 4'd9, 0, k, "host_rdata_o");
      add_row(op_write, 4'd5, 0, 0, "");
      add_row(op_retire, 0, 3, 0, "");
      add_row(op_read, 4'd9, 0, k + 3, "host_rdata_o");
      add_row(op_write, 4'd0, 0, 0, "");
      add_row(op_read, 4'd9, 0, 0, "host_rdata_o");
      add_row(op_read, 4'd10, 0, 0, "host_rdata_o");
      add_row(op_write, 4'd0, 1, 0, "");

      // io pulse kind in addr with bit 0 for request and bit 1 for response
      cur_test = 5;
      add_row(op_io, 4'd1, num_credits - 1, 0, "");
      add_row(op_pin, 0, 0, 0, "io_stall_o");
      add_row(op_read, 4'd8, 0, 1, "host_rdata_o");
      add_row(op_io, 4'd1, 1, 0, "");
      add_row(op_pin, 0, 0, 1, "io_stall_o");
      add_row(op_io, 4'd3, 4, 0, "");
      add_row(op_io, 4'd1, 2, 0, "");
      add_row(op_pin, 0, 0, 1, "io_stall_o");
      add_row(op_io, 4'd2, 1, 0, "");
      add_row(op_pin, 0, 0, 0, "io_stall_o");
      add_row(op_io, 4'd2, num_credits - 1, 0, "");
      add_row(op_read, 4'd8, 0, 0, "host_rdata_o");
      add_row(op_io, 4'd3, 2, 0, "");
      add_row(op_read, 4'd8, 0, 0, "host_rdata_o");
   endtask

   ////////////////////////////////////////////////////////////
   // row execution
   ////////////////////////////////////////////////////////////

   task automatic compare_value(input string sig, input logic [31:0] exp,
                                input logic [31:0] got);
      checks++;
      assert (got === exp)
      else
      begin
         $display("Fail %s: expected %h, got %h", sig, exp, got);
         errors++;
      end
   endtask

   task automatic apply_row(input row_t r);
      logic [31:0] got;
      int          cycles;
      logic        seen;

      @(negedge clk);
      case (r.op)
         op_write:
         begin
            host_we    = 1'b1;
            host_addr  = zynq_shell_pkg::host_reg_e'(r.addr);
            host_wdata = r.data;
            @(negedge clk);
            host_we = 1'b0;
         end
         op_read:
         begin
            host_addr = zynq_shell_pkg::host_reg_e'(r.addr);
            #(settle);
            compare_value($sformatf("%s[%0d]", r.sig, r.addr), r.exp, host_rdata);
         end
         op_pin:
         begin
            #(settle);
            case (r.sig)
               "io_stall_o":      got = {31'b0, io_stall};
               "core_reset_n_o":  got = {31'b0, core_reset_n};
               "irq_o":           got = {27'b0, irq};
               "axi_req_o.valid": got = {31'b0, axi_req.valid};
               default:           got = {31'b0, xlate_err};
            endcase
            compare_value(r.sig, r.exp, got);
         end
         op_retire, op_io:
         begin
            for (int n = 0; n < r.data; n++)
            begin
               retire  = (r.op == op_retire);
               io_req  = (r.op == op_io) && r.addr[0];
               io_resp = (r.op == op_io) && r.addr[1];
               @(negedge clk);
            end
            retire  = 1'b0;
            io_req  = 1'b0;
            io_resp = 1'b0;
         end
         default:
         begin
            mem_req.valid = 1'b1;
            mem_req.write = r.addr[0];
            mem_req.addr  = r.data;
            cycles = 0;
            seen   = 1'b0;
            while (!seen && (cycles < wait_limit))
            begin
               @(negedge clk);
               mem_req.valid = 1'b0;
               cycles++;
               #(settle);
               seen = axi_req.valid || xlate_err;
            end
            if (!seen)
            begin
               $display("no request and no error came out for address %h", r.data);
               errors++;
            end
            else
            begin
               checks++;
               assert (cycles == 1)
               else
               begin
                  $display("result for address %h came after %0d cycles instead of 1",
                           r.data, cycles);
                  errors++;
               end
               compare_value("axi_req_o.valid", r.sig == "axi_req_o.addr", axi_req.valid);
               compare_value("xlate_err_o", r.sig == "xlate_err_o", xlate_err);
               if (r.sig == "axi_req_o.addr")
               begin
                  compare_value("axi_req_o.write", r.addr[0], axi_req.write);
                  compare_value("axi_req_o.addr", r.exp, axi_req.addr);
               end
            end
            // the result lasts a single cycle
            @(negedge clk);
            #(settle);
            compare_value("axi_req_o.valid", 0, axi_req.valid);
            compare_value("xlate_err_o", 0, xlate_err);
         end
      endcase
   endtask

   initial
   begin
      int cycles;
      int first_err;

      host_we    = 1'b0;
      host_addr  = zynq_shell_pkg::reg_sys_reset_n;
      host_wdata = '0;
      retire     = 1'b0;
      io_req     = 1'b0;
      io_resp    = 1'b0;
      mem_req    = '0;
      errors     = 0;
      checks     = 0;
      void'($urandom(32'hfe48_6425));
      $readmemh("src/boot_rom.mem", rom_words);
      build_table();

      cycles = 0;
      while ((rst_n !== 1'b1) && (cycles < 40))
      begin
         @(negedge clk);
         cycles++;
      end
      if (rst_n !== 1'b1)
      begin
         $display("reset was still asserted after 40 cycles");
         errors++;
      end

      first_err = errors;
      for (int i = 0; i < rows.size(); i++)
      begin
         apply_row(rows[i]);
         if ((i == rows.size() - 1) || (rows[i + 1].test != rows[i].test))
         begin
            $display("test %0d, %s: %0d errors", rows[i].test, test_names[rows[i].test],
                     errors - first_err);
            first_err = errors;
         end
      end

      $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
      if (errors == 0)
      begin
         $display("Done: no errors");
      end
      else
      begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== zynq_shell.f ====
src/zynq_shell_pkg.sv
src/host_csr_bank.sv
src/boot_rom.sv
src/dram_addr_xlate.sv
src/io_credit_counter.sv
src/retire_counter.sv
src/zynq_shell.sv
verification/tb_clock_gen.sv
verification/tb_zynq_shell.sv

// ==== Bender.yml ====
package:
  name: zynq_shell

sources:
  - src/zynq_shell_pkg.sv
  - src/host_csr_bank.sv
  - src/boot_rom.sv
  - src/dram_addr_xlate.sv
  - src/io_credit_counter.sv
  - src/retire_counter.sv
  - src/zynq_shell.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_zynq_shell.sv

// ==== src/boot_rom.mem ====
// one 32-bit boot word per line, word 0 first
00000297
02028593
0005a503
00a5a023
30529073
f1402573
00100293
3002a073
10500073
ffdff06f
0badc0de
13579bdf
2468ace0
deadbeef
c001d00d
7e57ab1e
